//--- fpx_convert.f
verilog/fpx_pkg.sv
verilog/fpx_operand_if.sv
verilog/fpx_unpack.sv
verilog/fpx_operand_reg.sv
verilog/fpx_round_pack.sv
verilog/fpx_convert.sv
tb/fpx_convert_tb.sv

//--- tb/fpx_convert_tb.sv
// Self-checking testbench for the format converter with LFSR operands
// Expected results are queued per conversion and checked when done pulses
`timescale 1ns/100ps
`default_nettype none

module fpx_convert_tb import fpx_pkg::*; ();

    // Flag vector order is invalid, overflow, underflow, inexact
    localparam logic [3:0] F_INV  = 4'b1000;
    localparam logic [3:0] F_OVF  = 4'b0100;
    localparam logic [3:0] F_UNF  = 4'b0010;
    localparam logic [3:0] F_INEX = 4'b0001;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int CYCLE_LIMIT = 3000;

    // Which outputs a result compares, fp80 fp32 int32 from high bit down
    typedef struct packed {
        logic [2:0]  mask;
        logic [79:0] fp80;
        logic [31:0] fp32;
        logic [31:0] int32;
        logic [3:0]  flags;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [3:0]  mode;
    logic [1:0]  rounding_mode;
    logic [79:0] fp80_in;
    logic [31:0] fp32_in;
    logic [31:0] int32_in;
    logic [79:0] fp80_out;
    logic [31:0] fp32_out;
    logic [31:0] int32_out;
    logic        done;
    logic        flag_invalid;
    logic        flag_overflow;
    logic        flag_underflow;
    logic        flag_inexact;
    logic [3:0]  flags;

    expect_t     exp_q[$];
    expect_t     cur;
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          sent_count;
    int          done_count;

    fpx_convert dut (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .mode           (mode),
        .rounding_mode  (rounding_mode),
        .fp80_in        (fp80_in),
        .fp32_in        (fp32_in),
        .int32_in       (int32_in),
        .fp80_out       (fp80_out),
        .fp32_out       (fp32_out),
        .int32_out      (int32_out),
        .done           (done),
        .flag_invalid   (flag_invalid),
        .flag_overflow  (flag_overflow),
        .flag_underflow (flag_underflow),
        .flag_inexact   (flag_inexact)
    );

    assign flags = {flag_invalid, flag_overflow, flag_underflow, flag_inexact};

    // 20 ns clock
    always #10 clk = ~clk;

    //==========================================================================
    // Failure reporting and helpers
    //==========================================================================

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [79:0] got,
                                  input logic [79:0] want);
        $display("CHECK FAILED %s got %0h expected %0h", name, got, want);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit taken, first bit ends up highest
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic expect_t expect_of(input logic [2:0] mask, input logic [79:0] f80,
                                          input logic [31:0] f32, input logic [31:0] i32,
                                          input logic [3:0] fl);
        expect_t e;
        e.mask  = mask;
        e.fp80  = f80;
        e.fp32  = f32;
        e.int32 = i32;
        e.flags = fl;
        return e;
    endfunction

    // Exact FP80 image of an integer, leading one moved to bit 63
    function automatic logic [79:0] int_as_fp80(input logic [31:0] v);
        logic [31:0] m;
        int          p;
        m = v[31] ? (~v + 32'd1) : v;
        p = 0;
        if (m == 32'd0) begin
            return 80'd0;
        end
        for (int b = 0; b < 32; b++) begin
            if (m[b]) begin
                p = b;
            end
        end
        return {v[31], 15'(FP80_BIAS) + 15'(p), 64'(m) << (63 - p)};
    endfunction

    // One enable cycle, enable stays high until idle_cycle
    task automatic start_conv(input logic [3:0] m, input logic [1:0] r,
                              input logic [79:0] a80, input logic [31:0] a32,
                              input logic [31:0] ai, input expect_t e);
        @(posedge clk);
        #2;
        enable        = 1'b1;
        mode          = m;
        rounding_mode = r;
        fp80_in       = a80;
        fp32_in       = a32;
        int32_in      = ai;
        exp_q.push_back(e);
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        enable = 1'b0;
    endtask

    //==========================================================================
    // Checks
    //==========================================================================

    a_reset_quiet: assert property (@(posedge clk) reset |=> (!done && flags == 4'b0))
        else stop_with_error("done or a flag was high right after reset");

    // Back-to-back enables give back-to-back done pulses
    a_done_timing: assert property (
        @(posedge clk) disable iff (reset) 1'b1 |=> (done == $past(enable))
    ) else stop_with_error("done did not follow enable by exactly one cycle");

    a_flags_idle: assert property (@(posedge clk) disable iff (reset) !done |-> flags == 4'b0)
        else stop_with_error("a flag was raised while done was low");

    // Outputs settled during the previous cycle, read before the edge updates them
    always @(posedge clk) begin
        if (!reset && done === 1'b1) begin
            assert (exp_q.size() != 0)
                else stop_with_error("done pulsed with no conversion pending");
            cur = exp_q.pop_front();
            done_count++;
            if (cur.mask[2]) begin
                assert (fp80_out == cur.fp80)
                    else value_mismatch("fp80_out", fp80_out, cur.fp80);
            end
            if (cur.mask[1]) begin
                assert (fp32_out == cur.fp32)
                    else value_mismatch("fp32_out", 80'(fp32_out), 80'(cur.fp32));
            end
            if (cur.mask[0]) begin
                assert (int32_out == cur.int32)
                    else value_mismatch("int32_out", 80'(int32_out), 80'(cur.int32));
            end
            assert (flags == cur.flags)
                else value_mismatch("flags", 80'(flags), 80'(cur.flags));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_error("timeout, the run did not finish within the cycle limit");
        end
    end

    //==========================================================================
    // Stimulus
    //==========================================================================

    initial begin
        logic        s;
        logic [7:0]  e8;
        logic [22:0] frac;
        logic [39:0] low40;
        logic [14:0] e15;
        logic [31:0] a32;
        logic [31:0] ai;
        logic [79:0] a80;
        logic [3:0]  inex;
        clk = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        mode = 4'd0;
        rounding_mode = 2'd0;
        fp80_in = '0;
        fp32_in = '0;
        int32_in = '0;
        lfsr_state = 32'd39;
        cycle_count = 0;
        sent_count = 0;
        done_count = 0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        // Normal FP32 widened then narrowed back, exact under any rounding
        for (int i = 0; i < 200; i++) begin
            s    = 1'(take_bits(1));
            e8   = 8'(take_bits(8));
            frac = 23'(take_bits(23));
            if (e8 == 8'h00) e8 = 8'h01;
            if (e8 == 8'hFF) e8 = 8'hFE;
            a32 = {s, e8, frac};
            a80 = {s, 15'(e8) + 15'(FP80_BIAS - FP32_BIAS), 1'b1, frac, 40'b0};
            start_conv(MODE_FP32_TO_FP80, 2'(i % 4), '0, a32, '0,
                       expect_of(3'b100, a80, '0, '0, 4'b0));
            start_conv(MODE_FP80_TO_FP32, 2'(i % 4), a80, '0, '0,
                       expect_of(3'b010, '0, a32, '0, 4'b0));
            if (i % 4 == 3) idle_cycle();
        end

        // INT32 round trips, the first value is zero
        for (int i = 0; i < 201; i++) begin
            ai  = (i == 0) ? 32'd0 : 32'(take_bits(32));
            a80 = int_as_fp80(ai);
            start_conv(MODE_INT32_TO_FP80, RND_NEAREST, '0, '0, ai,
                       expect_of(3'b100, a80, '0, '0, 4'b0));
            start_conv(MODE_FP80_TO_INT32, 2'(i % 4), a80, '0, '0,
                       expect_of(3'b001, '0, '0, ai, 4'b0));
        end
        idle_cycle();

        // Narrowing with random dropped bits, a quarter of them exact
        for (int i = 0; i < 64; i++) begin
            s     = 1'(take_bits(1));
            e8    = 8'(take_bits(7)) + 8'd1;
            frac  = 23'(take_bits(23));
            low40 = 40'(take_bits(40));
            if (take_bits(2) == 64'd0) low40 = '0;
            a80  = {s, 15'(e8) + 15'(FP80_BIAS - FP32_BIAS), 1'b1, frac, low40};
            inex = (low40 != '0) ? F_INEX : 4'b0;
            start_conv(MODE_FP80_TO_FP32, RND_ZERO, a80, '0, '0,
                       expect_of(3'b010, '0, {s, e8, frac}, '0, inex));
            // Positive copy rounds up one unit when inexact
            a32 = {1'b0, e8, frac} + ((low40 != '0) ? 32'd1 : 32'd0);
            start_conv(MODE_FP80_TO_FP32, RND_UP, {1'b0, a80[78:0]}, '0, '0,
                       expect_of(3'b010, '0, a32, '0, inex));
        end
        idle_cycle();

        // Range limits of FP32 and INT32
        for (int i = 0; i < 16; i++) begin
            s   = 1'(take_bits(1));
            e15 = 15'(FP80_BIAS) + 15'd128 + 15'(take_bits(10));
            a80 = {s, e15, 1'b1, 63'(take_bits(63))};
            start_conv(MODE_FP80_TO_FP32, RND_NEAREST, a80, '0, '0,
                       expect_of(3'b010, '0, {s, 8'hFF, 23'b0}, '0, F_OVF | F_INEX));
            e15 = 15'(FP80_BIAS) - 15'd128 - 15'(take_bits(10));
            a80 = {s, e15, 1'b1, 63'(take_bits(63))};
            start_conv(MODE_FP80_TO_FP32, 2'(take_bits(2)), a80, '0, '0,
                       expect_of(3'b010, '0, {s, 31'b0}, '0, F_UNF | F_INEX));
            e15 = 15'(FP80_BIAS) + 15'd31 + 15'(take_bits(4)) + 15'(s);
            a80 = {s, e15, 1'b1, 63'(take_bits(63))};
            start_conv(MODE_FP80_TO_INT32, 2'(take_bits(2)), a80, '0, '0,
                       expect_of(3'b001, '0, '0, INT32_INDEFINITE, F_INV));
            idle_cycle();
        end

        // Special values and unsupported opcodes
        a80 = {1'b0, FP80_EXP_MAX, 2'b11, 62'(take_bits(62))};
        start_conv(MODE_FP80_TO_FP32, RND_NEAREST, a80, '0, '0,
                   expect_of(3'b010, '0, FP32_QNAN, '0, F_INV));
        start_conv(MODE_FP80_TO_INT32, RND_ZERO, a80, '0, '0,
                   expect_of(3'b001, '0, '0, INT32_INDEFINITE, F_INV));
        start_conv(MODE_FP32_TO_FP80, RND_NEAREST, '0, 32'hFF80_0000, '0,
                   expect_of(3'b100, {1'b1, FP80_EXP_MAX, 1'b1, 63'b0}, '0, '0, 4'b0));
        start_conv(4'd11, RND_NEAREST, a80, 32'h3F80_0000, 32'd5,
                   expect_of(3'b111, '0, '0, '0, F_INV));
        start_conv(4'd15, RND_UP, a80, 32'h4000_0000, 32'd9,
                   expect_of(3'b111, '0, '0, '0, F_INV));

        repeat (4) idle_cycle();
        if (done_count == sent_count) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_error("number of done pulses differs from number of conversions");
        end
    end

endmodule

`default_nettype wire

//--- verilog/fpx_convert.sv
// Top level of the format converter, enable starts a conversion and done
// pulses one cycle later with the results and flags
`timescale 1ns/100ps
`default_nettype none

module fpx_convert (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [3:0]  mode,
    input  logic [1:0]  rounding_mode,
    input  logic [79:0] fp80_in,
    input  logic [31:0] fp32_in,
    input  logic [31:0] int32_in,
    output logic [79:0] fp80_out,
    output logic [31:0] fp32_out,
    output logic [31:0] int32_out,
    output logic        done,
    output logic        flag_invalid,
    output logic        flag_overflow,
    output logic        flag_underflow,
    output logic        flag_inexact
);

    // Operand as unpacked this cycle and as held for the packer
    fpx_operand_if unpacked ();
    fpx_operand_if held ();

    // Producer
    fpx_unpack u_unpack (
        .enable        (enable),
        .mode          (mode),
        .rounding_mode (rounding_mode),
        .fp80_in       (fp80_in),
        .fp32_in       (fp32_in),
        .int32_in      (int32_in),
        .op            (unpacked)
    );

    // One entry buffer
    fpx_operand_reg u_operand_reg (
        .clk    (clk),
        .reset  (reset),
        .in_op  (unpacked),
        .out_op (held)
    );

    // Consumer
    fpx_round_pack u_round_pack (
        .op             (held),
        .fp80_out       (fp80_out),
        .fp32_out       (fp32_out),
        .int32_out      (int32_out),
        .done           (done),
        .flag_invalid   (flag_invalid),
        .flag_overflow  (flag_overflow),
        .flag_underflow (flag_underflow),
        .flag_inexact   (flag_inexact)
    );

endmodule

`default_nettype wire

//--- verilog/fpx_round_pack.sv
// Output stage of the converter, rounds the held operand to the target
// format and raises the IEEE exception flags while done is high
`timescale 1ns/100ps
`default_nettype none

module fpx_round_pack import fpx_pkg::*; (
    fpx_operand_if.sink op,
    output logic [79:0] fp80_out,
    output logic [31:0] fp32_out,
    output logic [31:0] int32_out,
    output logic        done,
    output logic        flag_invalid,
    output logic        flag_overflow,
    output logic        flag_underflow,
    output logic        flag_inexact
);

    // FP80 target
    logic signed [16:0] exp80;

    // FP32 target
    logic [24:0]        rnd32;
    logic               inc32;
    logic               lost32;
    logic signed [16:0] exp32;
    logic               ovf_inf32;

    // INT32 target
    logic               big_int;
    logic               tiny_int;
    logic [5:0]         sh_int;
    logic [95:0]        shifted;
    logic [31:0]        ipart;
    logic               guard_int;
    logic               sticky_int;
    logic               inc_int;
    logic [32:0]        rnd_int;
    logic               ovf_int;
    logic [31:0]        int_val;

    // Raw flags before qualification with done
    logic invalid_raw;
    logic overflow_raw;
    logic underflow_raw;
    logic inexact_raw;

    // Round increment for the x87 rounding control
    function automatic logic round_inc(input round_e rnd,
                                       input logic sign, lsb, guard, sticky);
        case (rnd)
            RND_NEAREST: return guard & (sticky | lsb);
            RND_DOWN:    return sign & (guard | sticky);
            RND_UP:      return ~sign & (guard | sticky);
            default:     return 1'b0;
        endcase
    endfunction

    //==========================================================================
    // Datapaths per target
    //==========================================================================

    // Widening is exact, only the bias changes
    assign exp80 = op.exp + FP80_BIAS;

    // 24 bit significand, guard at bit 39 and sticky below
    assign lost32 = op.sig[39] | (|op.sig[38:0]);
    assign inc32  = round_inc(op.rnd, op.sign, op.sig[40], op.sig[39], |op.sig[38:0]);
    assign rnd32  = {1'b0, op.sig[63:40]} + {24'b0, inc32};
    // Carry out of the significand bumps the exponent, fraction is then zero
    assign exp32  = op.exp + FP32_BIAS + signed'({16'b0, rnd32[24]});
    // Overflow goes to infinity unless rounding runs toward zero
    assign ovf_inf32 = (op.rnd == RND_NEAREST) ||
                       (op.rnd == RND_UP && !op.sign) ||
                       (op.rnd == RND_DOWN && op.sign);

    // Integer part is valid for exponents from -1 to 31
    assign big_int  = op.exp > 17'sd31;
    assign tiny_int = op.exp < -17'sd1;
    assign sh_int   = op.exp[5:0] + 6'd1;
    assign shifted  = {32'b0, op.sig} << sh_int;

    // Below one half only the sticky bit survives
    assign ipart      = tiny_int ? 32'd0 : shifted[95:64];
    assign guard_int  = tiny_int ? 1'b0 : shifted[63];
    assign sticky_int = tiny_int ? 1'b1 : |shifted[62:0];
    assign inc_int    = round_inc(op.rnd, op.sign, ipart[0], guard_int, sticky_int);
    assign rnd_int    = {1'b0, ipart} + {32'b0, inc_int};

    // Exactly -2**31 still fits
    assign ovf_int = big_int | rnd_int[32] |
                     (rnd_int[31] & (~op.sign | (|rnd_int[30:0])));
    assign int_val = op.sign ? (~rnd_int[31:0] + 32'd1) : rnd_int[31:0];

    //==========================================================================
    // Output select and flags
    //==========================================================================

    always_comb begin
        fp80_out      = '0;
        fp32_out      = '0;
        int32_out     = '0;
        invalid_raw   = 1'b0;
        overflow_raw  = 1'b0;
        underflow_raw = 1'b0;
        inexact_raw   = 1'b0;

        case (op.mode)
            MODE_FP32_TO_FP80, MODE_INT32_TO_FP80: begin
                case (op.cls)
                    CLS_ZERO: fp80_out = {op.sign, 79'b0};
                    CLS_INF:  fp80_out = {op.sign, FP80_EXP_MAX, 1'b1, 63'b0};
                    CLS_NAN: begin
                        fp80_out    = FP80_QNAN;
                        invalid_raw = 1'b1;
                    end
                    default:  fp80_out = {op.sign, exp80[14:0], op.sig};
                endcase
            end

            MODE_FP80_TO_FP32: begin
                case (op.cls)
                    CLS_ZERO: fp32_out = {op.sign, 31'b0};
                    CLS_INF:  fp32_out = {op.sign, 8'hFF, 23'b0};
                    CLS_NAN: begin
                        fp32_out    = FP32_QNAN;
                        invalid_raw = 1'b1;
                    end
                    default: begin
                        if (exp32 > 17'sd254) begin
                            overflow_raw = 1'b1;
                            inexact_raw  = 1'b1;
                            fp32_out = ovf_inf32 ? {op.sign, 8'hFF, 23'b0}
                                                 : {op.sign, 8'hFE, 23'h7F_FFFF};
                        end else if (exp32 < 17'sd1) begin
                            // No FP32 denormals, tiny results flush to zero
                            underflow_raw = 1'b1;
                            inexact_raw   = 1'b1;
                            fp32_out      = {op.sign, 31'b0};
                        end else begin
                            inexact_raw = lost32;
                            fp32_out    = {op.sign, exp32[7:0], rnd32[22:0]};
                        end
                    end
                endcase
            end

            MODE_FP80_TO_INT32: begin
                if (op.cls == CLS_NORMAL && !ovf_int) begin
                    int32_out   = int_val;
                    inexact_raw = guard_int | sticky_int;
                end else if (op.cls != CLS_ZERO) begin
                    // NaN, infinity or out of range, as x87 FIST does
                    int32_out   = INT32_INDEFINITE;
                    invalid_raw = 1'b1;
                end
            end

            default: invalid_raw = 1'b1;
        endcase
    end

    // Result is ready one cycle after enable
    assign done           = op.valid;
    assign flag_invalid   = op.valid & invalid_raw;
    assign flag_overflow  = op.valid & overflow_raw;
    assign flag_underflow = op.valid & underflow_raw;
    assign flag_inexact   = op.valid & inexact_raw;

    //==========================================================================
    // Checks
    //==========================================================================

    // Only narrowing to FP32 can overflow, and only from above the FP32 range
    a_ovf_mode: assert final (!flag_overflow ||
                              (op.mode == MODE_FP80_TO_FP32 && op.exp > 17'sd126))
        else $error("overflow raised for mode %0d exponent %0d", op.mode, op.exp);

    // Only the FP32 target can underflow, and only from below its range
    a_unf_mode: assert final (!flag_underflow ||
                              (op.mode == MODE_FP80_TO_FP32 && op.exp < -17'sd126))
        else $error("underflow raised for mode %0d exponent %0d", op.mode, op.exp);

endmodule

`default_nettype wire

//--- verilog/fpx_operand_reg.sv
// Pipeline buffer between unpacker and packer
// Holds one operand for a cycle so the next one can be unpacked meanwhile
`timescale 1ns/100ps
`default_nettype none

module fpx_operand_reg import fpx_pkg::*; (
    input  logic clk,
    input  logic reset,
    fpx_operand_if.sink   in_op,
    fpx_operand_if.source out_op
);

    // Loaded on every clock, no back-pressure exists
    always_ff @(posedge clk) begin
        if (reset) begin
            out_op.valid <= 1'b0;
            // Idle operand is a positive zero in mode 0
            out_op.mode  <= MODE_FP32_TO_FP80;
            out_op.rnd   <= RND_NEAREST;
            out_op.cls   <= CLS_ZERO;
            out_op.sign  <= 1'b0;
            out_op.exp   <= '0;
            out_op.sig   <= '0;
        end else begin
            out_op.valid <= in_op.valid;
            out_op.mode  <= in_op.mode;
            out_op.rnd   <= in_op.rnd;
            out_op.cls   <= in_op.cls;
            out_op.sign  <= in_op.sign;
            out_op.exp   <= in_op.exp;
            out_op.sig   <= in_op.sig;
        end
    end

    //==========================================================================
    // Checks
    //==========================================================================

    // The packer expects a held normal operand with its leading one at bit 63
    a_held_normalized: assert property (
        @(posedge clk) disable iff (reset)
        (out_op.valid && out_op.cls == CLS_NORMAL) |-> out_op.sig[63]
    ) else $error("held normal operand is not normalized");

endmodule

`default_nettype wire

//--- verilog/fpx_unpack.sv
// Input stage of the converter, picks the source named by the mode and
// turns it into a classified operand with a normalized significand
`timescale 1ns/100ps
`default_nettype none

module fpx_unpack import fpx_pkg::*; (
    input  logic        enable,
    input  logic [3:0]  mode,
    input  logic [1:0]  rounding_mode,
    input  logic [79:0] fp80_in,
    input  logic [31:0] fp32_in,
    input  logic [31:0] int32_in,
    fpx_operand_if.source op
);

    // Integer magnitude, sign is carried separately
    logic [31:0]        int_mag;
    // Significand before normalization, leading one somewhere below bit 64
    logic [63:0]        norm_in;
    // Exponent that goes with norm_in before the normalizing shift
    logic signed [16:0] exp_base;
    // Normalizing shift
    logic [5:0]         lz;

    // Leading zero count, a zero input returns zero
    function automatic logic [5:0] lzc64(input logic [63:0] v);
        logic [5:0] n;
        n = 6'd0;
        // Highest set bit wins since it is visited last
        for (int i = 0; i < 64; i++) begin
            if (v[i]) begin
                n = 6'(63 - i);
            end
        end
        return n;
    endfunction

    assign int_mag = int32_in[31] ? (~int32_in + 32'd1) : int32_in;

    always_comb begin
        op.valid = enable;
        // Unsupported opcodes pass through so the packer can flag them
        op.mode  = conv_mode_e'(mode);
        op.rnd   = round_e'(rounding_mode);
        op.cls   = CLS_ZERO;
        op.sign  = 1'b0;
        norm_in  = '0;
        exp_base = '0;

        case (mode)
            //==================================================================
            // FP32 source
            //==================================================================
            MODE_FP32_TO_FP80: begin
                op.sign = fp32_in[31];
                if (fp32_in[30:23] == 8'hFF) begin
                    op.cls  = (fp32_in[22:0] == '0) ? CLS_INF : CLS_NAN;
                    norm_in = {1'b1, fp32_in[22:0], 40'b0};
                end else if (fp32_in[30:23] != 8'h00) begin
                    op.cls   = CLS_NORMAL;
                    norm_in  = {1'b1, fp32_in[22:0], 40'b0};
                    exp_base = signed'({9'b0, fp32_in[30:23]}) - FP32_BIAS;
                end else if (fp32_in[22:0] != '0) begin
                    // Denormal 0.f * 2**-126, the shift below normalizes it
                    op.cls   = CLS_NORMAL;
                    norm_in  = {1'b0, fp32_in[22:0], 40'b0};
                    exp_base = 17'sd1 - FP32_BIAS;
                end
            end

            //==================================================================
            // INT32 source
            //==================================================================
            MODE_INT32_TO_FP80: begin
                op.sign  = int32_in[31];
                op.cls   = (int32_in == '0) ? CLS_ZERO : CLS_NORMAL;
                // Magnitude in the top word is worth 2**31 at bit 63
                norm_in  = {int_mag, 32'b0};
                exp_base = 17'sd31;
            end

            //==================================================================
            // FP80 source, shared by both narrowing modes
            //==================================================================
            MODE_FP80_TO_FP32, MODE_FP80_TO_INT32: begin
                op.sign = fp80_in[79];
                norm_in = fp80_in[63:0];
                if (fp80_in[78:64] == FP80_EXP_MAX) begin
                    op.cls = (fp80_in[62:0] == '0) ? CLS_INF : CLS_NAN;
                end else if (fp80_in[63:0] == '0) begin
                    op.cls = CLS_ZERO;
                end else begin
                    op.cls = CLS_NORMAL;
                    // Denormals use the minimum exponent and get normalized
                    if (fp80_in[78:64] == '0) begin
                        exp_base = 17'sd1 - FP80_BIAS;
                    end else begin
                        exp_base = signed'({2'b0, fp80_in[78:64]}) - FP80_BIAS;
                    end
                end
            end

            default: begin
                // Zero operand, the packer raises invalid on the opcode
                op.cls = CLS_ZERO;
            end
        endcase

        // Bring the leading one to bit 63 and compensate the exponent
        lz     = lzc64(norm_in);
        op.sig = norm_in << lz;
        op.exp = exp_base - signed'({11'b0, lz});
    end

endmodule

`default_nettype wire

//--- verilog/fpx_operand_if.sv
// One unpacked operand passed between the converter pipeline stages
// The producing stage uses the source modport and the consuming stage the sink
`timescale 1ns/100ps
`default_nettype none

interface fpx_operand_if import fpx_pkg::*; ();

    // Conversion in flight this cycle
    logic               valid;

    // Opcode and rounding control travel with the operand
    conv_mode_e         mode;
    round_e             rnd;

    // Class and sign of the value
    op_class_e          cls;
    logic               sign;

    // Unbiased exponent and significand with the leading one at bit 63
    // Value is sig / 2**63 * 2**exp for normal operands
    logic signed [16:0] exp;
    logic [63:0]        sig;

    modport source (output valid, mode, rnd, cls, sign, exp, sig);
    modport sink   (input  valid, mode, rnd, cls, sign, exp, sig);

endinterface

`default_nettype wire

//--- verilog/fpx_pkg.sv
// Shared types and format constants for the x87 style format converter
// Imported by each pipeline stage and by the testbench
`default_nettype none

package fpx_pkg;

    //==========================================================================
    // Opcodes and control encodings
    //==========================================================================

    // Conversion opcodes with the encodings of the full twelve mode converter
    typedef enum logic [3:0] {
        MODE_FP32_TO_FP80  = 4'd0,
        MODE_FP80_TO_FP32  = 4'd2,
        MODE_INT32_TO_FP80 = 4'd5,
        MODE_FP80_TO_INT32 = 4'd7
    } conv_mode_e;

    // x87 rounding control field
    typedef enum logic [1:0] {
        RND_NEAREST = 2'd0,
        RND_DOWN    = 2'd1,
        RND_UP      = 2'd2,
        RND_ZERO    = 2'd3
    } round_e;

    // Operand class after unpacking
    // Denormal inputs are normalized and show up as CLS_NORMAL
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } op_class_e;

    //==========================================================================
    // Format constants
    //==========================================================================

    // Exponent biases sized to match the unbiased operand exponent
    localparam logic signed [16:0] FP80_BIAS = 17'sd16383;
    localparam logic signed [16:0] FP32_BIAS = 17'sd127;

    // All ones FP80 exponent for infinity and NaN
    localparam logic [14:0] FP80_EXP_MAX = 15'h7FFF;

    // Default quiet NaN in each float format
    // Negative sign and top fraction bit only, the x87 real indefinite
    localparam logic [79:0] FP80_QNAN = 80'hFFFF_C000_0000_0000_0000;
    localparam logic [31:0] FP32_QNAN = 32'hFFC0_0000;

    // Integer indefinite for invalid or out of range integer results
    localparam logic [31:0] INT32_INDEFINITE = 32'h8000_0000;

endpackage

`default_nettype wire
